// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= exu_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/exu_tb.sv ====
/*
 * execute unit testbench
 * reset state, back-to-back ALU issues, random and special divides
 * and an issue that arrives while the divider is busy
 */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defines.svh"

module exu_tb;

    logic               clk;
    logic               rst_i;
    logic               issue_i;
    exu_pkg::exu_op_e   op_i;
    exu_pkg::word_t     src1_i;
    exu_pkg::word_t     src2_i;
    exu_pkg::word_t     result_o;
    logic               done_o;
    logic               busy_o;

    int err_cnt  = 0;
    int test_cnt = 0;
    int fail_cnt = 0;

    exu_top i_exu_top (
        .clk      ( clk      ),
        .rst_i    ( rst_i    ),
        .issue_i  ( issue_i  ),
        .op_i     ( op_i     ),
        .src1_i   ( src1_i   ),
        .src2_i   ( src2_i   ),
        .result_o ( result_o ),
        .done_o   ( done_o   ),
        .busy_o   ( busy_o   )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // protocol checks
    // --------------------------------------------------
    a_done_busy_apart: assert property (
        @(posedge clk) disable iff (rst_i) !(done_o && busy_o)
    ) else begin
        $display("** Error at %0d ns: done_o and busy_o high together", $time);
        err_cnt++;
    end

    // a divide always ends with done in the cycle busy drops
    a_busy_ends_done: assert property (
        @(posedge clk) disable iff (rst_i) $fell(busy_o) |-> done_o
    ) else begin
        $display("** Error at %0d ns: busy_o fell without done_o", $time);
        err_cnt++;
    end

    // --------------------------------------------------
    // reference rules
    // --------------------------------------------------
    function automatic exu_pkg::word_t alu_expect(exu_pkg::exu_op_e op,
                                                  exu_pkg::word_t a, exu_pkg::word_t b);
        logic [`EXU_SHAMT_W-1:0] sh;
        sh = b[`EXU_SHAMT_W-1:0];
        case (op)
            exu_pkg::OP_ADD: return a + b;
            exu_pkg::OP_SUB: return a - b;
            exu_pkg::OP_AND: return a & b;
            exu_pkg::OP_OR:  return a | b;
            exu_pkg::OP_XOR: return a ^ b;
            exu_pkg::OP_SLL: return a << sh;
            exu_pkg::OP_SRL: return a >> sh;
            exu_pkg::OP_SRA: return $signed(a) >>> sh;
            exu_pkg::OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:         return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic exu_pkg::word_t div_expect(exu_pkg::exu_op_e op,
                                                  exu_pkg::word_t a, exu_pkg::word_t b);
        logic           sgn;
        exu_pkg::word_t q;
        exu_pkg::word_t r;
        sgn = (op == exu_pkg::OP_DIV) || (op == exu_pkg::OP_REM);
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = a;
            r = '0;
        end else if (sgn) begin
            // truncating division, remainder keeps the dividend sign
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return (op == exu_pkg::OP_REM || op == exu_pkg::OP_REMU) ? r : q;
    endfunction

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic check_word(string what, exu_pkg::word_t got, exu_pkg::word_t exp);
        assert (got === exp) else begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic drive_issue(exu_pkg::exu_op_e op, exu_pkg::word_t a, exu_pkg::word_t b);
        @(posedge clk);
        #2;
        issue_i = 1'b1;
        op_i    = op;
        src1_i  = a;
        src2_i  = b;
    endtask

    task automatic drop_issue();
        @(posedge clk);
        #2;
        issue_i = 1'b0;
    endtask

    task automatic wait_done();
        int  cycles;
        bit  seen;
        seen = 1'b0;
        for (cycles = 0; cycles < `EXU_DIV_STEPS + 10 && !seen; cycles++) begin
            if (done_o) begin
                seen = 1'b1;
            end else begin
                check_word("busy_o during divide", busy_o, 1);
                @(posedge clk);
                #2;
            end
        end
        if (!seen) begin
            $display("timeout at %0d ns: done_o never came after a divide", $time);
            err_cnt++;
        end
    endtask

    task automatic run_div(exu_pkg::exu_op_e op, exu_pkg::word_t a, exu_pkg::word_t b);
        drive_issue(op, a, b);
        drop_issue();
        check_word("busy_o after divide issue", busy_o, 1);
        wait_done();
        check_word($sformatf("%s %h, %h", op.name(), a, b), result_o, div_expect(op, a, b));
    endtask

    task automatic report_test(string name, int errs_before);
        test_cnt++;
        if (err_cnt != errs_before) begin
            fail_cnt++;
        end
        $display("test %-12s %s", name, (err_cnt == errs_before) ? "ok" : "FAILED");
    endtask

    // --------------------------------------------------
    // tests
    // --------------------------------------------------
    task automatic test_alu(int count);
        exu_pkg::exu_op_e op;
        exu_pkg::word_t   exp;
        int               i;
        op  = exu_pkg::exu_op_e'($urandom_range(9, 0));
        drive_issue(op, $urandom(), $urandom());
        exp = alu_expect(op, src1_i, src2_i);
        for (i = 1; i <= count; i++) begin
            @(posedge clk);
            #2;
            check_word("done_o after alu issue", done_o, 1);
            check_word($sformatf("alu %s", op.name()), result_o, exp);
            if (i < count) begin
                op     = exu_pkg::exu_op_e'($urandom_range(9, 0));
                op_i   = op;
                src1_i = $urandom();
                src2_i = $urandom();
                exp    = alu_expect(op, src1_i, src2_i);
            end else begin
                issue_i = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        check_word("done_o after last alu", done_o, 0);
    endtask

    task automatic test_issue_busy();
        exu_pkg::word_t a;
        exu_pkg::word_t b;
        a = $urandom();
        b = ($urandom() >> 12) | 32'd1;
        drive_issue(exu_pkg::OP_DIVU, a, b);
        drop_issue();
        repeat (3) @(posedge clk);
        #2;
        // this add must not be taken
        issue_i = 1'b1;
        op_i    = exu_pkg::OP_ADD;
        src1_i  = ~a;
        src2_i  = 32'd7;
        drop_issue();
        wait_done();
        check_word("divide result after ignored issue", result_o, a / b);
        repeat (5) begin
            @(posedge clk);
            #2;
            check_word("extra done_o after divide", done_o, 0);
        end
    endtask

    initial begin
        int errs;
        void'($urandom(32'h7c95ec22));
        rst_i   = 1'b1;
        issue_i = 1'b0;
        op_i    = exu_pkg::OP_ADD;
        src1_i  = '0;
        src2_i  = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_i = 1'b0;

        errs = err_cnt;
        check_word("done_o after reset", done_o, 0);
        check_word("busy_o after reset", busy_o, 0);
        check_word("result_o after reset", result_o, '0);
        report_test("reset", errs);

        errs = err_cnt;
        test_alu(200);
        report_test("alu", errs);

        errs = err_cnt;
        repeat (40) begin
            run_div(exu_pkg::exu_op_e'(10 + $urandom_range(3, 0)),
                    $urandom(), $urandom() >> $urandom_range(31, 0));
        end
        report_test("div_random", errs);

        errs = err_cnt;
        run_div(exu_pkg::OP_DIV,  $urandom(), '0);
        run_div(exu_pkg::OP_DIVU, $urandom(), '0);
        run_div(exu_pkg::OP_REM,  $urandom(), '0);
        run_div(exu_pkg::OP_REMU, $urandom(), '0);
        run_div(exu_pkg::OP_DIV,  32'h8000_0000, 32'hffff_ffff);
        run_div(exu_pkg::OP_REM,  32'h8000_0000, 32'hffff_ffff);
        run_div(exu_pkg::OP_DIVU, 32'h8000_0000, 32'hffff_ffff);
        run_div(exu_pkg::OP_REMU, 32'h8000_0000, 32'hffff_ffff);
        report_test("div_special", errs);

        errs = err_cnt;
        test_issue_busy();
        report_test("issue_busy", errs);

        $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+rtl
rtl/exu_pkg.sv
rtl/alu_core.sv
rtl/div_unit.sv
rtl/exu_ctrl.sv
rtl/exu_top.sv
bench/exu_tb.sv

// ==== rtl/alu_core.sv ====
/*
 * integer ALU
 * single-cycle arithmetic, logic, shift and set-less-than
 * for the RV32 execute stage; divide opcodes give zero
 */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defines.svh"

module alu_core (
    input  wire exu_pkg::exu_op_e   op_i,
    input  wire exu_pkg::word_t     a_i,
    input  wire exu_pkg::word_t     b_i,
    output exu_pkg::word_t          result_o
);

    logic [`EXU_SHAMT_W-1:0] shamt;
    logic                    lt_signed;
    logic                    lt_unsigned;

    // only the low bits of b take part in a shift
    assign shamt = b_i[`EXU_SHAMT_W-1:0];

    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    // --------------------------------------------------
    // operation select
    // --------------------------------------------------
    always_comb begin
        case (op_i)
            exu_pkg::OP_ADD: begin
                result_o = a_i + b_i;
            end
            exu_pkg::OP_SUB: begin
                result_o = a_i - b_i;
            end
            exu_pkg::OP_AND: begin
                result_o = a_i & b_i;
            end
            exu_pkg::OP_OR: begin
                result_o = a_i | b_i;
            end
            exu_pkg::OP_XOR: begin
                result_o = a_i ^ b_i;
            end
            exu_pkg::OP_SLL: begin
                result_o = a_i << shamt;
            end
            exu_pkg::OP_SRL: begin
                result_o = a_i >> shamt;
            end
            exu_pkg::OP_SRA: begin
                // arithmetic shift keeps the sign bit
                result_o = exu_pkg::word_t'($signed(a_i) >>> shamt);
            end
            exu_pkg::OP_SLT: begin
                result_o = exu_pkg::word_t'(lt_signed);
            end
            exu_pkg::OP_SLTU: begin
                result_o = exu_pkg::word_t'(lt_unsigned);
            end
            default: begin
                // divide group, handled by the divider
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/div_unit.sv ====
/*
 * iterative divider
 * restoring shift-subtract divider for div, divu, rem and remu
 * one check cycle catches divide by zero and signed overflow,
 * all other divisions take one step per quotient bit and a
 * final sign fix
 */
`timescale 1ns/1ps
`default_nettype none
`include "exu_defines.svh"

module div_unit (
    input  wire                       clk,
    input  wire                       rst_i,
    input  wire                       start_i,
    input  wire exu_pkg::div_kind_t   kind_i,
    input  wire exu_pkg::word_t       dividend_i,
    input  wire exu_pkg::word_t       divisor_i,
    output exu_pkg::word_t            result_o,
    output logic                      done_o,
    output logic                      busy_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_CHECK,
        S_RUN,
        S_FIX
    } state_t;

    typedef logic [$clog2(`EXU_DIV_STEPS+1)-1:0] cnt_t;

    state_t               state_q;
    cnt_t                 step_cnt;
    exu_pkg::div_kind_t   kind_q;
    exu_pkg::word_t       dividend_q;
    exu_pkg::word_t       divisor_q;
    exu_pkg::word_t       quo_q;
    exu_pkg::word_t       rem_q;
    logic                 neg_quo_q;
    logic                 neg_rem_q;

    logic                 dividend_neg;
    logic                 divisor_neg;
    exu_pkg::word_t       abs_dividend;
    exu_pkg::word_t       abs_divisor;
    logic                 div_by_zero;
    logic                 overflow;
    logic [`EXU_XLEN:0]   shifted;
    logic [`EXU_XLEN:0]   trial;

    assign busy_o = (state_q != S_IDLE);

    // --------------------------------------------------
    // operand checks
    // --------------------------------------------------
    assign dividend_neg = kind_q.is_signed & dividend_q[`EXU_XLEN-1];
    assign divisor_neg  = kind_q.is_signed & divisor_q[`EXU_XLEN-1];
    assign abs_dividend = dividend_neg ? -dividend_q : dividend_q;
    assign abs_divisor  = divisor_neg ? -divisor_q : divisor_q;

    assign div_by_zero = (divisor_q == '0);
    // most negative value over minus one
    assign overflow = kind_q.is_signed
                    & (dividend_q == {1'b1, {(`EXU_XLEN-1){1'b0}}})
                    & (&divisor_q);

    // partial remainder with the next dividend bit shifted in
    assign shifted = {rem_q, quo_q[`EXU_XLEN-1]};
    assign trial   = shifted - {1'b0, divisor_q};

    // --------------------------------------------------
    // control FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= S_IDLE;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    if (div_by_zero || overflow) begin
                        state_q <= S_IDLE;
                        done_o  <= 1'b1;
                    end else begin
                        state_q <= S_RUN;
                    end
                end
                S_RUN: begin
                    if (step_cnt == cnt_t'(1)) begin
                        state_q <= S_FIX;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                    done_o  <= 1'b1;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // datapath
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        case (state_q)
            S_IDLE: begin
                if (start_i) begin
                    kind_q     <= kind_i;
                    dividend_q <= dividend_i;
                    divisor_q  <= divisor_i;
                end
            end
            S_CHECK: begin
                if (div_by_zero) begin
                    result_o <= kind_q.is_rem ? dividend_q : '1;
                end else if (overflow) begin
                    result_o <= kind_q.is_rem ? '0 : dividend_q;
                end
                // loop works on magnitudes
                rem_q     <= '0;
                quo_q     <= abs_dividend;
                divisor_q <= abs_divisor;
                step_cnt  <= cnt_t'(`EXU_DIV_STEPS);
                neg_quo_q <= dividend_neg ^ divisor_neg;
                neg_rem_q <= dividend_neg;
            end
            S_RUN: begin
                if (!trial[`EXU_XLEN]) begin
                    rem_q <= trial[`EXU_XLEN-1:0];
                    quo_q <= {quo_q[`EXU_XLEN-2:0], 1'b1};
                end else begin
                    rem_q <= shifted[`EXU_XLEN-1:0];
                    quo_q <= {quo_q[`EXU_XLEN-2:0], 1'b0};
                end
                step_cnt <= step_cnt - 1'b1;
            end
            default: begin
                // remainder follows the dividend sign
                if (kind_q.is_rem) begin
                    result_o <= neg_rem_q ? -rem_q : rem_q;
                end else begin
                    result_o <= neg_quo_q ? -quo_q : quo_q;
                end
            end
        endcase
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (rst_i) start_i |-> !busy_o
    );

    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst_i) done_o |=> !done_o
    );

endmodule

`default_nettype wire

// ==== rtl/exu_ctrl.sv ====
/*
 * execute control
 * accepts issues, routes them to the ALU or the divider,
 * holds the merged result and raises done and busy
 */
`timescale 1ns/1ps
`default_nettype none

module exu_ctrl (
    input  wire                       clk,
    input  wire                       rst_i,
    input  wire                       issue_i,
    input  wire exu_pkg::exu_op_e     op_i,
    input  wire exu_pkg::word_t       src1_i,
    input  wire exu_pkg::word_t       src2_i,
    output exu_pkg::exu_op_e          alu_op_o,
    input  wire exu_pkg::word_t       alu_result_i,
    output logic                      div_start_o,
    output exu_pkg::div_kind_t        div_kind_o,
    output exu_pkg::word_t            div_dividend_o,
    output exu_pkg::word_t            div_divisor_o,
    input  wire exu_pkg::word_t       div_result_i,
    input  wire                       div_done_i,
    input  wire                       div_busy_i,
    output exu_pkg::word_t            result_o,
    output logic                      done_o,
    output logic                      busy_o
);

    logic accept;
    logic is_div;

    // --------------------------------------------------
    // issue decode
    // --------------------------------------------------
    assign is_div = op_i inside {exu_pkg::OP_DIV, exu_pkg::OP_DIVU,
                                 exu_pkg::OP_REM, exu_pkg::OP_REMU};

    assign accept = issue_i & ~busy_o & ~div_busy_i;

    assign alu_op_o    = op_i;
    assign div_start_o = accept & is_div;

    assign div_kind_o.is_signed = (op_i == exu_pkg::OP_DIV) | (op_i == exu_pkg::OP_REM);
    assign div_kind_o.is_rem    = (op_i == exu_pkg::OP_REM) | (op_i == exu_pkg::OP_REMU);

    assign div_dividend_o = src1_i;
    assign div_divisor_o  = src2_i;

    // --------------------------------------------------
    // result merge
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            result_o <= '0;
            done_o   <= 1'b0;
            busy_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (accept && !is_div) begin
                result_o <= alu_result_i;
                done_o   <= 1'b1;
            end
            if (div_start_o) begin
                busy_o <= 1'b1;
            end
            // divider finishes only while busy
            if (div_done_i) begin
                result_o <= div_result_i;
                done_o   <= 1'b1;
                busy_o   <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    a_div_done_busy: assert property (
        @(posedge clk) disable iff (rst_i) div_done_i |-> busy_o && !accept
    );

endmodule

`default_nettype wire

// ==== rtl/exu_defines.svh ====
/*
 * execute unit constants
 * word width, opcode field width, shift amount width and
 * the number of divider iterations
 */
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// --------------------------------------------------
// data path
// --------------------------------------------------
`define EXU_XLEN        32
`define EXU_SHAMT_W     5

// opcode field, wide enough for all fourteen operations
`define EXU_OP_W        4

// --------------------------------------------------
// divider
// --------------------------------------------------
// one quotient bit per step
`define EXU_DIV_STEPS   32

`endif

// ==== rtl/exu_pkg.sv ====
/*
 * execute unit types
 * data word, operation codes and the divide kind that the
 * control block hands to the divider
 */
`default_nettype none
`include "exu_defines.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0] word_t;

    // alu group first, divide group last
    typedef enum logic [`EXU_OP_W-1:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_SLT  = 4'd8,
        OP_SLTU = 4'd9,
        OP_DIV  = 4'd10,
        OP_DIVU = 4'd11,
        OP_REM  = 4'd12,
        OP_REMU = 4'd13
    } exu_op_e;

    // signed operands, remainder instead of quotient
    typedef struct packed {
        logic is_signed;
        logic is_rem;
    } div_kind_t;

endpackage

`default_nettype wire

// ==== rtl/exu_top.sv ====
/*
 * execute unit top
 * ALU, divider and control block of the RV32 execute stage
 */
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  wire                       clk,
    input  wire                       rst_i,
    input  wire                       issue_i,
    input  wire exu_pkg::exu_op_e     op_i,
    input  wire exu_pkg::word_t       src1_i,
    input  wire exu_pkg::word_t       src2_i,
    output exu_pkg::word_t            result_o,
    output logic                      done_o,
    output logic                      busy_o
);

    exu_pkg::exu_op_e     alu_op;
    exu_pkg::word_t       alu_result;
    logic                 div_start;
    exu_pkg::div_kind_t   div_kind;
    exu_pkg::word_t       div_dividend;
    exu_pkg::word_t       div_divisor;
    exu_pkg::word_t       div_result;
    logic                 div_done;
    logic                 div_busy;

    exu_ctrl u_exu_ctrl_0 (
        .clk            ( clk           ),
        .rst_i          ( rst_i         ),
        .issue_i        ( issue_i       ),
        .op_i           ( op_i          ),
        .src1_i         ( src1_i        ),
        .src2_i         ( src2_i        ),
        .alu_op_o       ( alu_op        ),
        .alu_result_i   ( alu_result    ),
        .div_start_o    ( div_start     ),
        .div_kind_o     ( div_kind      ),
        .div_dividend_o ( div_dividend  ),
        .div_divisor_o  ( div_divisor   ),
        .div_result_i   ( div_result    ),
        .div_done_i     ( div_done      ),
        .div_busy_i     ( div_busy      ),
        .result_o       ( result_o      ),
        .done_o         ( done_o        ),
        .busy_o         ( busy_o        )
    );

    // operands go straight to the ALU
    alu_core u_alu_core_0 (
        .op_i           ( alu_op        ),
        .a_i            ( src1_i        ),
        .b_i            ( src2_i        ),
        .result_o       ( alu_result    )
    );

    div_unit u_div_unit_0 (
        .clk            ( clk           ),
        .rst_i          ( rst_i         ),
        .start_i        ( div_start     ),
        .kind_i         ( div_kind      ),
        .dividend_i     ( div_dividend  ),
        .divisor_i      ( div_divisor   ),
        .result_o       ( div_result    ),
        .done_o         ( div_done      ),
        .busy_o         ( div_busy      )
    );

endmodule

`default_nettype wire
